/* src/led_matrix_params.svh */
// panel geometry, UART timing and display timing constants
// include wherever sizes or timing are needed

`ifndef LED_MATRIX_PARAMS_SVH
`define LED_MATRIX_PARAMS_SVH

// panel geometry
`define PANEL_COLUMNS 16          // pixels per row
`define PANEL_ROWS 16
`define ROW_PAIRS 8               // rows scanned, top and bottom at once

// colour depth, one bit plane per colour bit
`define COLOR_BITS 2

// serial command link
`define UART_TICKS_PER_BIT 8      // clk_root cycles per bit

// display time of plane 0, doubled for each higher plane
`define OE_BASE_CYCLES 32

// command opcodes
`define OPCODE_PIXEL 8'h50
`define OPCODE_ENABLE 8'h45

`endif

/* src/led_matrix_pkg.sv */
// shared types for the LED matrix controller
// pixel, address and settings byte layouts used by every stage
`default_nettype none

package led_matrix_pkg;

`include "led_matrix_params.svh"

    typedef logic [$clog2(`PANEL_COLUMNS)-1:0] col_addr_t;
    typedef logic [$clog2(`ROW_PAIRS)-1:0] row_pair_t;
    typedef logic [$clog2(`COLOR_BITS)-1:0] plane_t;

    // address byte of a pixel write, row msb picks the bank
    typedef struct packed {
        logic [3:0] row;
        col_addr_t column;
    } pixel_addr_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

    typedef struct packed {
        logic [1:0] pad;
        logic [`COLOR_BITS-1:0] red;
        logic [`COLOR_BITS-1:0] green;
        logic [`COLOR_BITS-1:0] blue;
    } pixel_t;

    typedef struct packed {
        logic [2:0] pad;
        logic [`COLOR_BITS-1:0] brightness_enable;  // one bit per plane
        rgb_t rgb_enable;
    } enables_t;

    // payload byte, meaning depends on the opcode
    typedef union packed {
        pixel_t pixel;
        enables_t enables;
    } data_byte_u;

endpackage

`default_nettype wire

/* src/scan_if.sv */
// scan position from the sequencer to the fetch stage
// one strobe per column, with the row pair and plane being shown
`timescale 1ns/1ns
`default_nettype none

interface scan_if import led_matrix_pkg::*; ();

    logic fetch_strobe;     // one cycle per column
    col_addr_t column;
    row_pair_t row_pair;
    plane_t plane;

    modport scan_src (
        output fetch_strobe,
        output column,
        output row_pair,
        output plane
    );

    modport scan_dst (
        input fetch_strobe,
        input column,
        input row_pair,
        input plane
    );

endinterface

`default_nettype wire

/* src/serial_rx.sv */
// UART 8N1 receiver, lsb first, with a two-flop input synchronizer
// pulses rx_valid for one cycle at mid stop bit for each good frame
`timescale 1ns/1ns
`default_nettype none

`include "led_matrix_params.svh"

module serial_rx (
    input  logic       clk_root,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int TICK_W = $clog2(`UART_TICKS_PER_BIT);
    localparam logic [TICK_W-1:0] HALF_BIT = TICK_W'(`UART_TICKS_PER_BIT / 2 - 1);
    localparam logic [TICK_W-1:0] FULL_BIT = TICK_W'(`UART_TICKS_PER_BIT - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t state;
    logic rx_meta;
    logic rx_sync;
    logic rx_prev;              // for start edge detect
    logic [TICK_W-1:0] tick;
    logic [2:0] bit_idx;
    logic [7:0] shift_reg;

    // line idles high
    always_ff @(posedge clk_root) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state    <= RX_IDLE;
            tick     <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                        tick  <= '0;
                    end
                end
                RX_START: begin  // wait to the middle of the start bit
                    if (tick == HALF_BIT) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch, not a start
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick == FULL_BIT) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (tick == FULL_BIT) begin
                        state    <= RX_IDLE;
                        rx_valid <= rx_sync;  // framing error drops the byte
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == RX_DATA && tick == FULL_BIT) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};  // lsb arrives first
        end
    end

    assign rx_byte = shift_reg;

endmodule

`default_nettype wire

/* src/command_decoder.sv */
// command parser for pixel writes (0x50 addr pixel) and enables (0x45 byte)
// unknown opcodes are dropped while idle
`timescale 1ns/1ns
`default_nettype none

`include "led_matrix_params.svh"

module command_decoder
    import led_matrix_pkg::*;
(
    input  logic        clk_root,
    input  logic        rst,
    input  logic [7:0]  rx_byte,
    input  logic        rx_valid,
    output logic        write_en,
    output pixel_addr_t write_addr,
    output pixel_t      write_pixel,
    output enables_t    settings
);

    localparam enables_t ENABLES_ALL = '{
        pad: 3'b000,
        brightness_enable: '1,
        rgb_enable: 3'b111
    };

    typedef enum logic [1:0] {CMD_IDLE, CMD_ADDR, CMD_DATA} cmd_state_t;

    cmd_state_t state;
    logic pixel_cmd;            // opcode being served
    data_byte_u payload;

    // same byte read as a pixel or as enables
    assign payload = rx_byte;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state     <= CMD_IDLE;
            pixel_cmd <= 1'b0;
            write_en  <= 1'b0;
            settings  <= ENABLES_ALL;
        end else begin
            write_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    CMD_IDLE: begin
                        if (rx_byte == `OPCODE_PIXEL) begin
                            pixel_cmd <= 1'b1;
                            state     <= CMD_ADDR;
                        end else if (rx_byte == `OPCODE_ENABLE) begin
                            pixel_cmd <= 1'b0;
                            state     <= CMD_DATA;  // no address byte
                        end
                    end
                    CMD_ADDR: state <= CMD_DATA;
                    CMD_DATA: begin
                        state <= CMD_IDLE;
                        if (pixel_cmd) begin
                            write_en <= 1'b1;
                        end else begin
                            settings <= payload.enables;
                        end
                    end
                    default: state <= CMD_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (rx_valid && state == CMD_ADDR) begin
            write_addr <= pixel_addr_t'(rx_byte);
        end
        if (rx_valid && state == CMD_DATA && pixel_cmd) begin
            write_pixel <= payload.pixel;
        end
    end

endmodule

`default_nettype wire

/* src/frame_ram.sv */
// two-bank framebuffer, top rows 0-7 and bottom rows 8-15
// byte write port, registered read of both halves of a row pair
`timescale 1ns/1ns
`default_nettype none

`include "led_matrix_params.svh"

module frame_ram
    import led_matrix_pkg::*;
(
    input  logic        clk_root,
    input  logic        write_en,
    input  pixel_addr_t write_addr,
    input  pixel_t      write_pixel,
    input  logic        read_en,
    input  row_pair_t   read_row,
    input  col_addr_t   read_column,
    output pixel_t      read_top,
    output pixel_t      read_bottom
);

    localparam int DEPTH = `ROW_PAIRS * `PANEL_COLUMNS;

    pixel_t bank_top [DEPTH];
    pixel_t bank_bottom [DEPTH];

    logic bank_sel;
    logic [$clog2(DEPTH)-1:0] write_index;

    assign bank_sel    = write_addr.row[3];
    assign write_index = {write_addr.row[2:0], write_addr.column};

    always_ff @(posedge clk_root) begin
        if (write_en && !bank_sel) bank_top[write_index] <= write_pixel;
        if (write_en && bank_sel) bank_bottom[write_index] <= write_pixel;
        if (read_en) begin
            read_top    <= bank_top[{read_row, read_column}];
            read_bottom <= bank_bottom[{read_row, read_column}];
        end
    end

endmodule

`default_nettype wire

/* src/pixel_fetch.sv */
// reads the framebuffer at the scan position and slices out one bit plane
// rgb outputs are valid two cycles after the fetch strobe
`timescale 1ns/1ns
`default_nettype none

module pixel_fetch
    import led_matrix_pkg::*;
(
    input  logic      clk_root,
    input  logic      rst,
    scan_if.scan_dst  scan,
    input  enables_t  settings,
    output logic      read_en,
    output row_pair_t read_row,
    output col_addr_t read_column,
    input  pixel_t    read_top,
    input  pixel_t    read_bottom,
    output rgb_t      rgb_top,
    output rgb_t      rgb_bottom
);

    plane_t plane_d;            // plane of the read in flight
    logic read_valid;

    // one plane bit per channel, masked by the enables
    function automatic rgb_t slice_plane(pixel_t px, plane_t p, enables_t en);
        rgb_t out;
        out.red   = px.red[p] & en.brightness_enable[p] & en.rgb_enable.red;
        out.green = px.green[p] & en.brightness_enable[p] & en.rgb_enable.green;
        out.blue  = px.blue[p] & en.brightness_enable[p] & en.rgb_enable.blue;
        return out;
    endfunction

    assign read_en     = scan.fetch_strobe;
    assign read_row    = scan.row_pair;
    assign read_column = scan.column;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            read_valid <= 1'b0;
            plane_d    <= '0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            read_valid <= scan.fetch_strobe;
            plane_d    <= scan.plane;
            if (read_valid) begin
                rgb_top    <= slice_plane(read_top, plane_d, settings);
                rgb_bottom <= slice_plane(read_bottom, plane_d, settings);
            end
        end
    end

endmodule

`default_nettype wire

/* src/matrix_scan.sv */
// panel scan sequencer: shift a row, latch it, show it for the plane's time
// plane is the inner loop, row pair the outer one
`timescale 1ns/1ns
`default_nettype none

`include "led_matrix_params.svh"

module matrix_scan
    import led_matrix_pkg::*;
(
    input  logic      clk_root,
    input  logic      rst,
    scan_if.scan_src  scan,
    output logic      clk_pixel,
    output logic      row_latch,
    output logic      oe_n,
    output row_pair_t row_address
);

    // shift steps run two per column, strobe on even steps
    localparam int LAST_STROBE = 2 * (`PANEL_COLUMNS - 1);
    localparam int CLK_LAST = 2 * `PANEL_COLUMNS;        // clk_pixel trails by two steps
    localparam int SHIFT_LAST = 2 * `PANEL_COLUMNS + 1;  // falling edge of the last pulse
    localparam int STEP_W = $clog2(SHIFT_LAST + 1);
    localparam int DISP_MAX = `OE_BASE_CYCLES << (`COLOR_BITS - 1);
    localparam int DISP_W = $clog2(DISP_MAX);

    typedef enum logic [1:0] {ST_SHIFT, ST_SETTLE, ST_LATCH, ST_DISPLAY} scan_state_t;

    scan_state_t state;
    logic [STEP_W-1:0] step;
    logic [DISP_W-1:0] disp_cnt;
    logic [DISP_W-1:0] disp_last;
    plane_t plane;
    row_pair_t row;

    assign disp_last = DISP_W'((`OE_BASE_CYCLES << plane) - 1);

    // position is stable across the whole shift pass
    assign scan.row_pair = row;
    assign scan.plane    = plane;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state    <= ST_SHIFT;
            step     <= '0;
            disp_cnt <= '0;
            plane    <= '0;
            row      <= '0;
        end else begin
            case (state)
                ST_SHIFT: begin
                    if (step == STEP_W'(SHIFT_LAST)) begin
                        state <= ST_SETTLE;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                ST_SETTLE: state <= ST_LATCH;
                ST_LATCH: begin
                    state    <= ST_DISPLAY;
                    disp_cnt <= '0;
                end
                ST_DISPLAY: begin
                    if (disp_cnt == disp_last) begin
                        state <= ST_SHIFT;
                        step  <= '0;
                        if (plane == plane_t'(`COLOR_BITS - 1)) begin
                            plane <= '0;
                            row   <= (row == row_pair_t'(`ROW_PAIRS - 1)) ? '0 : row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        disp_cnt <= disp_cnt + 1'b1;
                    end
                end
                default: state <= ST_SHIFT;
            endcase
        end
    end

    // registered panel outputs, one cycle behind the state
    always_ff @(posedge clk_root) begin
        if (rst) begin
            scan.fetch_strobe <= 1'b0;
            scan.column       <= '0;
            clk_pixel         <= 1'b0;
            row_latch         <= 1'b0;
            oe_n              <= 1'b1;
            row_address       <= '0;
        end else begin
            scan.fetch_strobe <= (state == ST_SHIFT) && !step[0]
                                 && (step <= STEP_W'(LAST_STROBE));
            scan.column       <= col_addr_t'(step >> 1);
            // high two steps after the strobe, covering fetch latency
            clk_pixel         <= (state == ST_SHIFT) && !step[0]
                                 && (step >= STEP_W'(2)) && (step <= STEP_W'(CLK_LAST));
            row_latch         <= (state == ST_LATCH);
            oe_n              <= (state != ST_DISPLAY);
            if (state == ST_LATCH) begin
                row_address <= row;
            end
        end
    end

endmodule

`default_nettype wire

/* src/led_matrix_top.sv */
// LED matrix controller top: UART commands in, HUB75 panel signals out
// pipeline is receive, decode, store, fetch, scan
`timescale 1ns/1ns
`default_nettype none

module led_matrix_top
    import led_matrix_pkg::*;
(
    input  logic      clk_root,
    input  logic      rst,
    input  logic      uart_rx,
    output rgb_t      rgb_top,
    output rgb_t      rgb_bottom,
    output logic      clk_pixel,
    output logic      row_latch,
    output logic      oe_n,
    output row_pair_t row_address
);

    logic [7:0] rx_byte;
    logic rx_valid;
    logic write_en;
    pixel_addr_t write_addr;
    pixel_t write_pixel;
    enables_t settings;
    logic read_en;
    row_pair_t read_row;
    col_addr_t read_column;
    pixel_t read_top;
    pixel_t read_bottom;

    scan_if scan_bus ();

    serial_rx u_serial_rx (
        .clk_root (clk_root),
        .rst      (rst),
        .rx       (uart_rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    command_decoder u_command_decoder (
        .clk_root    (clk_root),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .write_pixel (write_pixel),
        .settings    (settings)
    );

    frame_ram u_frame_ram (
        .clk_root    (clk_root),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .write_pixel (write_pixel),
        .read_en     (read_en),
        .read_row    (read_row),
        .read_column (read_column),
        .read_top    (read_top),
        .read_bottom (read_bottom)
    );

    pixel_fetch u_pixel_fetch (
        .clk_root    (clk_root),
        .rst         (rst),
        .scan        (scan_bus.scan_dst),
        .settings    (settings),
        .read_en     (read_en),
        .read_row    (read_row),
        .read_column (read_column),
        .read_top    (read_top),
        .read_bottom (read_bottom),
        .rgb_top     (rgb_top),
        .rgb_bottom  (rgb_bottom)
    );

    matrix_scan u_matrix_scan (
        .clk_root    (clk_root),
        .rst         (rst),
        .scan        (scan_bus.scan_src),
        .clk_pixel   (clk_pixel),
        .row_latch   (row_latch),
        .oe_n        (oe_n),
        .row_address (row_address)
    );

endmodule

`default_nettype wire

/* tb/tb_led_matrix.sv */
// self-checking testbench for the LED matrix controller
// sends UART commands, mirrors the framebuffer and checks the panel scan
`timescale 1ns/1ns
`default_nettype none

`include "led_matrix_params.svh"

module tb_led_matrix
    import led_matrix_pkg::*;
;

    localparam int BYTE_CYCLES = 10 * `UART_TICKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = 2 * (800 * BYTE_CYCLES + 6 * 1600);
    localparam int PASSES_PER_FRAME = 2 * `ROW_PAIRS;

    logic clk_root;
    logic rst;
    logic uart_rx;
    rgb_t rgb_top;
    rgb_t rgb_bottom;
    logic clk_pixel;
    logic row_latch;
    logic oe_n;
    row_pair_t row_address;

    pixel_t ref_mem [256];      // mirror of every pixel write
    enables_t ref_enables = 8'h1F;
    logic [31:0] lcg_state = 32'd92756;
    int window_first = 1;       // upcoming latch indices whose shift pass is checked
    int window_last = 0;
    int latch_count = 0;
    int cycles = 0;

    led_matrix_top UUT (
        .clk_root    (clk_root),
        .rst         (rst),
        .uart_rx     (uart_rx),
        .rgb_top     (rgb_top),
        .rgb_bottom  (rgb_bottom),
        .clk_pixel   (clk_pixel),
        .row_latch   (row_latch),
        .oe_n        (oe_n),
        .row_address (row_address)
    );

    always #5 clk_root = ~clk_root;

    task automatic check_rgb(input rgb_t expected, input rgb_t actual, input string name);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "rgb mismatch");
        end
    endtask

    task automatic check_row(input row_pair_t expected, input row_pair_t actual,
                             input string name);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "row mismatch");
        end
    endtask

    task automatic check_count(input int expected, input int actual, input string name);
        if (actual != expected) begin
            $display("ERROR at %0t ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // one plane bit per channel gated by the plane and channel enables
    function automatic rgb_t expected_rgb(input row_pair_t rp, input plane_t plane,
                                          input col_addr_t column, input logic bottom);
        pixel_t px;
        logic plane_on;
        rgb_t res;
        px = ref_mem[{bottom, rp, column}];    // row msb is the bank
        plane_on = ref_enables.brightness_enable[plane];
        res.red = px.red[plane] & plane_on & ref_enables.rgb_enable.red;
        res.green = px.green[plane] & plane_on & ref_enables.rgb_enable.green;
        res.blue = px.blue[plane] & plane_on & ref_enables.rgb_enable.blue;
        return res;
    endfunction

    // one 8N1 frame lsb first, starting and ending 1 ns after a rising edge
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        int i;
        frame = {1'b1, value, 1'b0};
        for (i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (`UART_TICKS_PER_BIT) @(posedge clk_root);
            #1;
        end
    endtask

    task automatic send_pixel_write(input logic [7:0] addr, input pixel_t value);
        send_byte(`OPCODE_PIXEL);
        send_byte(addr);
        send_byte(value);
        ref_mem[addr] = value;
    endtask

    task automatic send_enables(input enables_t value);
        send_byte(`OPCODE_ENABLE);
        send_byte(value);
        ref_enables = value;
    endtask

    // skip the pass that may have started during the last write and check the frame after it
    task automatic check_next_frame();
        int start;
        start = latch_count;
        window_first = start + 2;
        window_last = start + 1 + PASSES_PER_FRAME;
        while (latch_count < window_last) @(posedge clk_root);
        #1;
    endtask

    always @(posedge clk_root) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    // scan structure checked on every pass, shifted data inside the check window
    row_pair_t next_row;
    plane_t next_plane;
    plane_t shown_plane;
    int pulses;
    int oe_low;
    int oe_periods;             // completed display periods
    logic clk_prev;
    int upcoming;

    always @(negedge clk_root) begin
        if (rst) begin
            next_row = '0;
            next_plane = '0;
            shown_plane = '0;
            pulses = 0;
            oe_low = 0;
            oe_periods = 0;
            clk_prev = 1'b0;
        end else begin
            upcoming = latch_count + 1;
            if (clk_pixel && !clk_prev) begin
                check_count(1, int'(oe_n), "oe_n while shifting");
                if (upcoming >= window_first && upcoming <= window_last) begin
                    check_rgb(expected_rgb(next_row, next_plane, col_addr_t'(pulses), 1'b0),
                              rgb_top, "rgb_top");
                    check_rgb(expected_rgb(next_row, next_plane, col_addr_t'(pulses), 1'b1),
                              rgb_bottom, "rgb_bottom");
                end
                pulses++;
            end
            clk_prev = clk_pixel;
            if (row_latch) begin
                check_count(`PANEL_COLUMNS, pulses, "clk_pixel pulses before latch");
                check_row(next_row, row_address, "row_address");
                check_count(latch_count, oe_periods, "oe_n low periods before latch");
                pulses = 0;
                shown_plane = next_plane;
                if (next_plane == plane_t'(`COLOR_BITS - 1)) begin
                    next_plane = '0;
                    next_row = next_row + 1'b1;     // wraps after the last row pair
                end else begin
                    next_plane = next_plane + 1'b1;
                end
                latch_count++;
            end
            if (!oe_n) begin
                oe_low++;
            end else if (oe_low != 0) begin
                check_count(`OE_BASE_CYCLES << shown_plane, oe_low, "oe_n low cycles");
                oe_low = 0;
                oe_periods++;
            end
        end
    end

    initial begin
        int a;
        clk_root = 1'b0;
        rst = 1'b1;
        uart_rx = 1'b1;     // line idles high
        repeat (3) @(posedge clk_root);
        #1;
        rst = 1'b0;

        @(negedge clk_root);
        check_count(1, int'(oe_n), "oe_n after reset");
        check_count(0, int'(clk_pixel), "clk_pixel after reset");
        check_count(0, int'(row_latch), "row_latch after reset");
        @(posedge clk_root);
        #1;

        // fill the whole panel with random pixels
        for (a = 0; a < 256; a++) begin
            lcg_state = lcg_next(lcg_state);
            send_pixel_write(8'(a), pixel_t'({2'b00, lcg_state[21:16]}));
        end
        check_next_frame();

        // plane 1 with red and blue only
        send_enables(8'h15);
        check_next_frame();

        // all enables back on and a junk opcode before one more write
        send_enables(8'h1F);
        send_byte(8'hA7);
        send_pixel_write(8'h9C, pixel_t'(~ref_mem[8'h9C] & 8'h3F));
        check_next_frame();

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/led_matrix_pkg.sv
src/scan_if.sv
src/serial_rx.sv
src/command_decoder.sv
src/frame_ram.sv
src/pixel_fetch.sv
src/matrix_scan.sv
src/led_matrix_top.sv
tb/tb_led_matrix.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_led_matrix -f vlog.f -o sim_led_matrix \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_led_matrix > sim.log 2>&1
cat sim.log
grep -q '>>> FAIL' sim.log && exit 1 || exit 0
